// ==== Makefile ====
# Verilator build for the two-slot execute back end

VERILATOR ?= verilator
TOP       ?= tb_exu_top
FILELIST  ?= exu.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== exu.f ====
logic/exu_pkg.sv
logic/operand_forward.sv
logic/int_alu.sv
logic/mul_partial.sv
logic/mem_result_select.sv
logic/stage_regs.sv
logic/exu_top.sv
test/dmem_model.sv
test/tb_exu_top.sv

// ==== logic/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [63:0]           dword_t;    // Product or partial addend
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_PASS2 = 4'd10                      // Result is operand 2
    } alu_op_t;

    // One-hot writeback source, slot B only
    typedef struct packed {
        logic alu;
        logic load;
        logic mul_lo;
        logic mul_hi;
    } wb_sel_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rs1_addr;
        word_t     rs1_data;                   // Register file value, before forwarding
        reg_addr_t rs2_addr;
        word_t     rs2_data;
        word_t     imm;
        logic      src1_pc;                    // Operand 1 is pc
        logic      src2_imm;                   // Operand 2 is imm
        alu_op_t   alu_op;
        logic      rf_we;
        reg_addr_t rf_waddr;
    } slot_in_t;

    typedef struct packed {
        wb_sel_t wb_sel;
        logic    mul_signed;
        logic    mem_we;                       // Store
    } slot_b_ctl_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_port_t;

    typedef struct packed {
        word_t     alu_a;
        word_t     alu_b;
        logic      we_a;
        reg_addr_t waddr_a;
        logic      we_b;
        reg_addr_t waddr_b;
        wb_sel_t   wb_sel;
        logic      mem_wr;                     // Store in MEM
        dword_t    mul_add_lo;
        dword_t    mul_add_hi;
    } ex_mem_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
    } dmem_rsp_t;

endpackage

`default_nettype wire

// ==== logic/exu_top.sv ====
`default_nettype none

module exu_top import exu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  slot_in_t    slot_a,
    input  slot_in_t    slot_b,                // Younger of the pair
    input  slot_b_ctl_t ctl_b,
    output dmem_req_t   dmem_req,
    input  dmem_rsp_t   dmem_rsp,
    output wb_port_t    wb_a,
    output wb_port_t    wb_b,
    output logic        stall
);

    word_t    a1;
    word_t    a2;
    word_t    b1;
    word_t    b2;
    word_t    res_a;
    word_t    res_b;
    word_t    wdata_b;
    dword_t   add_lo;
    dword_t   add_hi;
    ex_mem_t  ex_next;
    ex_mem_t  ex_mem;
    wb_port_t mem_a;
    wb_port_t mem_b;
    wb_port_t wb_a_next;
    wb_port_t wb_b_next;

    // Only ALU results are forwarded out of MEM
    assign mem_a = '{we: ex_mem.we_a, waddr: ex_mem.waddr_a, wdata: ex_mem.alu_a};
    assign mem_b = '{we: ex_mem.we_b & ex_mem.wb_sel.alu, waddr: ex_mem.waddr_b,
                     wdata: ex_mem.alu_b};

    operand_forward fwd0 (
        .slot_a (slot_a),
        .slot_b (slot_b),
        .mem_a  (mem_a),
        .mem_b  (mem_b),
        .wb_a   (wb_a),
        .wb_b   (wb_b),
        .a1     (a1),
        .a2     (a2),
        .b1     (b1),
        .b2     (b2)
    );

    int_alu alu_a (.op(slot_a), .rs1(a1), .rs2(a2), .result(res_a));
    int_alu alu_b (.op(slot_b), .rs1(b1), .rs2(b2), .result(res_b));

    mul_partial mul0 (
        .x         (b1),
        .y         (b2),
        .is_signed (ctl_b.mul_signed),
        .addend_lo (add_lo),
        .addend_hi (add_hi)
    );

    assign ex_next = '{alu_a: res_a, alu_b: res_b,
                       we_a: slot_a.rf_we, waddr_a: slot_a.rf_waddr,
                       we_b: slot_b.rf_we, waddr_b: slot_b.rf_waddr,
                       wb_sel: ctl_b.wb_sel, mem_wr: ctl_b.mem_we,
                       mul_add_lo: add_lo, mul_add_hi: add_hi};

    // Request goes out from EX, completes in MEM
    assign dmem_req = '{rd: ctl_b.wb_sel.load, wr: ctl_b.mem_we, addr: res_b, wdata: b2};

    mem_result_select sel0 (.ex_mem(ex_mem), .rdata(dmem_rsp.rdata), .wdata_b(wdata_b));

    assign wb_a_next = '{we: ex_mem.we_a, waddr: ex_mem.waddr_a, wdata: ex_mem.alu_a};
    assign wb_b_next = '{we: ex_mem.we_b, waddr: ex_mem.waddr_b, wdata: wdata_b};

    stage_regs regs0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_next   (ex_next),
        .mem_ready (dmem_rsp.ready),
        .wb_a_next (wb_a_next),
        .wb_b_next (wb_b_next),
        .ex_mem    (ex_mem),
        .wb_a      (wb_a),
        .wb_b      (wb_b),
        .stall     (stall)
    );

endmodule

`default_nettype wire

// ==== logic/int_alu.sv ====
`default_nettype none

module int_alu import exu_pkg::*; (
    input  slot_in_t op,
    input  word_t    rs1,                      // Forwarded
    input  word_t    rs2,                      // Forwarded
    output word_t    result
);

    word_t      op1;
    word_t      op2;
    logic [4:0] shamt;

    assign op1   = op.src1_pc  ? op.pc  : rs1;
    assign op2   = op.src2_imm ? op.imm : rs2;
    assign shamt = op2[4:0];

    always_comb begin
        case (op.alu_op)
            ALU_ADD: begin
                result = op1 + op2;
            end
            ALU_SUB: begin
                result = op1 - op2;
            end
            ALU_AND: begin
                result = op1 & op2;
            end
            ALU_OR: begin
                result = op1 | op2;
            end
            ALU_XOR: begin
                result = op1 ^ op2;
            end
            ALU_SLL: begin
                result = op1 << shamt;
            end
            ALU_SRL: begin
                result = op1 >> shamt;
            end
            ALU_SRA: begin
                result = $signed(op1) >>> shamt;
            end
            ALU_SLT: begin
                result = {31'd0, $signed(op1) < $signed(op2)};
            end
            ALU_SLTU: begin
                result = {31'd0, op1 < op2};
            end
            ALU_PASS2: begin
                result = op2;                  // e.g. load upper immediate
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mem_result_select.sv ====
`default_nettype none

module mem_result_select import exu_pkg::*; (
    input  ex_mem_t ex_mem,
    input  word_t   rdata,
    output word_t   wdata_b
);

    dword_t product;

    assign product = ex_mem.mul_add_lo + ex_mem.mul_add_hi;    // Second multiply stage

    // AND-OR mux, select is one-hot
    assign wdata_b = ({XLEN{ex_mem.wb_sel.alu}}    & ex_mem.alu_b)
                   | ({XLEN{ex_mem.wb_sel.load}}   & rdata)
                   | ({XLEN{ex_mem.wb_sel.mul_lo}} & product[31:0])
                   | ({XLEN{ex_mem.wb_sel.mul_hi}} & product[63:32]);

endmodule

`default_nettype wire

// ==== logic/mul_partial.sv ====
`default_nettype none

module mul_partial import exu_pkg::*; (
    input  word_t  x,
    input  word_t  y,
    input  logic   is_signed,
    output dword_t addend_lo,
    output dword_t addend_hi
);

    logic signed [32:0] x_ext;
    logic signed [32:0] y_ext;
    logic signed [16:0] y_lo;                  // Low half, always non-negative
    logic signed [16:0] y_hi;                  // Upper 17 bits of extended y
    logic signed [63:0] prod_lo;
    logic signed [63:0] prod_hi;

    // A 33-bit signed view covers both signed and unsigned operands
    assign x_ext = {is_signed & x[XLEN-1], x};
    assign y_ext = {is_signed & y[XLEN-1], y};

    assign y_lo = {1'b0, y[15:0]};
    assign y_hi = y_ext[32:16];

    assign prod_lo = x_ext * y_lo;
    assign prod_hi = x_ext * y_hi;

    // Sum of the two is x * y modulo 2^64
    assign addend_lo = prod_lo;
    assign addend_hi = prod_hi << 16;

endmodule

`default_nettype wire

// ==== logic/operand_forward.sv ====
`default_nettype none

module operand_forward import exu_pkg::*; (
    input  slot_in_t slot_a,
    input  slot_in_t slot_b,
    input  wb_port_t mem_a,
    input  wb_port_t mem_b,
    input  wb_port_t wb_a,
    input  wb_port_t wb_b,
    output word_t    a1,
    output word_t    a2,
    output word_t    b1,
    output word_t    b2
);

    // Later checks override earlier ones, so the youngest writer is tested last
    function automatic word_t fwd(reg_addr_t rs, word_t rf_data);
        word_t v;
        v = rf_data;
        if (rs != '0) begin                    // r0 reads as the file value
            if (wb_a.we && wb_a.waddr == rs) begin
                v = wb_a.wdata;
            end
            if (wb_b.we && wb_b.waddr == rs) begin
                v = wb_b.wdata;
            end
            if (mem_a.we && mem_a.waddr == rs) begin
                v = mem_a.wdata;
            end
            if (mem_b.we && mem_b.waddr == rs) begin
                v = mem_b.wdata;               // Younger slot wins
            end
        end
        return v;
    endfunction

    always_comb begin
        a1 = fwd(slot_a.rs1_addr, slot_a.rs1_data);
        a2 = fwd(slot_a.rs2_addr, slot_a.rs2_data);
        b1 = fwd(slot_b.rs1_addr, slot_b.rs1_data);
        b2 = fwd(slot_b.rs2_addr, slot_b.rs2_data);
    end

endmodule

`default_nettype wire

// ==== logic/stage_regs.sv ====
`default_nettype none

module stage_regs import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  ex_mem_t  ex_next,
    input  logic     mem_ready,
    input  wb_port_t wb_a_next,
    input  wb_port_t wb_b_next,
    output ex_mem_t  ex_mem,
    output wb_port_t wb_a,
    output wb_port_t wb_b,
    output logic     stall
);

    logic mem_access;

    assign mem_access = ex_mem.wb_sel.load | ex_mem.mem_wr;
    assign stall      = mem_access & ~mem_ready;   // Wait for the data port

    // EX/MEM holds while the access is pending
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem <= ex_next;
        end
    end

    // MEM/WB takes a bubble on stall so nothing writes back twice
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_a <= '0;
            wb_b <= '0;
        end else if (stall) begin
            wb_a.we <= 1'b0;
            wb_b.we <= 1'b0;
        end else begin
            wb_a <= wb_a_next;
            wb_b <= wb_b_next;
        end
    end

endmodule

`default_nettype wire

// ==== test/dmem_model.sv ====
`default_nettype none

module dmem_model import exu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  dmem_req_t req,
    input  logic      stall,
    output dmem_rsp_t rsp,
    output int        write_count
);
    timeunit 1ns;
    timeprecision 1ps;

    word_t       mem [64];
    logic        pending;
    logic        pend_wr;
    word_t       pend_addr;
    word_t       pend_wdata;
    logic [1:0]  wait_cnt;
    logic [31:0] lfsr;

    // Fibonacci LFSR, taps 32 22 2 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = word_t'(i * 4) ^ 32'h5a5a_0000;   // Byte address XOR pattern
        end
    end

    assign rsp.ready = pending && wait_cnt == 2'd0;
    assign rsp.rdata = pending ? mem[pend_addr[7:2]] : '0;

    always @(posedge clk) begin
        logic [31:0] s1;
        logic [31:0] s2;
        logic [1:0]  draw;
        s1   = lfsr_next(lfsr);
        s2   = lfsr_next(s1);
        draw = {s1[0], s2[0]};
        if (!rst_n) begin
            pending     <= 1'b0;
            wait_cnt    <= '0;
            lfsr        <= 32'h2a46_b707;
            write_count <= 0;
        end else begin
            if (pending && wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
            if (pending && wait_cnt == 2'd0) begin
                if (pend_wr) begin
                    mem[pend_addr[7:2]] <= pend_wdata;     // Only on the ready cycle
                    write_count         <= write_count + 1;
                end
                pending <= 1'b0;
            end
            if ((req.rd || req.wr) && !stall) begin      // Access moves into MEM
                pending    <= 1'b1;
                pend_wr    <= req.wr;
                pend_addr  <= req.addr;
                pend_wdata <= req.wdata;
                wait_cnt   <= (draw == 2'd3) ? 2'd2 : draw;
                lfsr       <= s2;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_exu_top.sv ====
`default_nettype none

module tb_exu_top import exu_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [3:0] SEL_ALU  = 4'b1000;
    localparam logic [3:0] SEL_LOAD = 4'b0100;
    localparam logic [3:0] SEL_LO   = 4'b0010;
    localparam logic [3:0] SEL_HI   = 4'b0001;

    logic        clk = 1'b0;
    logic        rst_n;
    slot_in_t    slot_a;
    slot_in_t    slot_b;
    slot_b_ctl_t ctl_b;
    dmem_req_t   dmem_req;
    dmem_rsp_t   dmem_rsp;
    wb_port_t    wb_a;
    wb_port_t    wb_b;
    logic        stall;
    int          write_count;

    string       names [$];
    slot_in_t    tab_a [$];
    slot_in_t    tab_b [$];
    slot_b_ctl_t tab_c [$];
    word_t       tab_ea [$];
    word_t       tab_eb [$];
    wb_port_t    exp_q [$];
    string       name_q [$];
    bit          load_q [$];
    int          errors = 0;
    int          checks = 0;
    int          stores = 0;
    int          cycles = 0;
    int          limit;

    exu_top dut0 (.clk(clk), .rst_n(rst_n), .slot_a(slot_a), .slot_b(slot_b), .ctl_b(ctl_b),
                  .dmem_req(dmem_req), .dmem_rsp(dmem_rsp), .wb_a(wb_a), .wb_b(wb_b),
                  .stall(stall));

    dmem_model mem0 (.clk(clk), .rst_n(rst_n), .req(dmem_req), .stall(stall),
                     .rsp(dmem_rsp), .write_count(write_count));

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, %0d writebacks never arrived",
                     cycles, exp_q.size());
            $display("test failed");
            $finish;
        end
    end

    function automatic slot_in_t mk(alu_op_t op, reg_addr_t r1, word_t d1, reg_addr_t r2,
                                    word_t d2, word_t imm, logic s1pc, logic s2imm,
                                    logic we, reg_addr_t rd);
        return '{pc: 32'h100, rs1_addr: r1, rs1_data: d1, rs2_addr: r2, rs2_data: d2,
                 imm: imm, src1_pc: s1pc, src2_imm: s2imm, alu_op: op, rf_we: we,
                 rf_waddr: rd};
    endfunction

    // Full 64-bit product from extended operands
    function automatic word_t ref_mul(word_t x, word_t y, bit sgn, bit hi);
        logic [63:0] xe;
        logic [63:0] ye;
        logic [63:0] p;
        xe = sgn ? {{32{x[31]}}, x} : {32'd0, x};
        ye = sgn ? {{32{y[31]}}, y} : {32'd0, y};
        p  = xe * ye;
        return hi ? p[63:32] : p[31:0];
    endfunction

    task automatic add_row(string n, slot_in_t a, slot_in_t b, logic [3:0] sel, logic sgn,
                           logic st, word_t ea, word_t eb);
        names.push_back(n);
        tab_a.push_back(a);
        tab_b.push_back(b);
        tab_c.push_back(slot_b_ctl_t'{wb_sel: sel, mul_signed: sgn, mem_we: st});
        tab_ea.push_back(ea);
        tab_eb.push_back(eb);
    endtask

    task automatic build_table();
        slot_in_t two;
        two = mk(ALU_ADD, 20, 1, 21, 0, 1, 0, 1, 1, 11);            // 1 + 1
        add_row("add_sub", mk(ALU_ADD, 20, 5, 21, 7, 0, 0, 0, 1, 1),
                mk(ALU_SUB, 22, 10, 23, 3, 0, 0, 0, 1, 2), SEL_ALU, 0, 0, 12, 7);
        add_row("and_or_imm", mk(ALU_AND, 20, 32'hf0f0, 0, 0, 32'h0ff0, 0, 1, 1, 3),
                mk(ALU_OR, 21, 32'hf000, 0, 0, 32'h000f, 0, 1, 1, 4), SEL_ALU, 0, 0,
                32'h00f0, 32'hf00f);
        add_row("xor_sll", mk(ALU_XOR, 20, 32'hff00ff00, 21, 32'h0f0f0f0f, 0, 0, 0, 1, 5),
                mk(ALU_SLL, 22, 1, 23, 35, 0, 0, 0, 1, 6), SEL_ALU, 0, 0, 32'hf00ff00f, 8);
        add_row("srl_sra", mk(ALU_SRL, 20, 32'h80000000, 0, 0, 4, 0, 1, 1, 7),
                mk(ALU_SRA, 21, 32'h80000000, 0, 0, 4, 0, 1, 1, 8), SEL_ALU, 0, 0,
                32'h08000000, 32'hf8000000);
        add_row("slt_sltu", mk(ALU_SLT, 20, 32'hffffffff, 21, 1, 0, 0, 0, 1, 9),
                mk(ALU_SLTU, 22, 32'hffffffff, 23, 1, 0, 0, 0, 1, 10), SEL_ALU, 0, 0, 1, 0);
        add_row("pc_pass2", mk(ALU_ADD, 20, 0, 0, 0, 32'h20, 1, 1, 1, 11),
                mk(ALU_PASS2, 0, 0, 0, 0, 32'h12345000, 0, 1, 1, 12), SEL_ALU, 0, 0,
                32'h120, 32'h12345000);
        // Stale register file data of 0 must be replaced by forwarding
        add_row("fwd_mem", mk(ALU_ADD, 11, 0, 12, 0, 0, 0, 0, 1, 13),
                mk(ALU_ADD, 11, 0, 0, 0, 1, 0, 1, 1, 14), SEL_ALU, 0, 0,
                32'h12345120, 32'h121);
        add_row("fwd_wb", mk(ALU_ADD, 12, 0, 13, 0, 0, 0, 0, 1, 15),
                mk(ALU_ADD, 11, 0, 0, 0, 0, 0, 1, 1, 1), SEL_ALU, 0, 0,
                32'h2468a120, 32'h120);
        add_row("same_dest", mk(ALU_PASS2, 0, 0, 0, 0, 32'haaaa, 0, 1, 1, 2),
                mk(ALU_PASS2, 0, 0, 0, 0, 32'hbbbb, 0, 1, 1, 2), SEL_ALU, 0, 0,
                32'haaaa, 32'hbbbb);
        add_row("fwd_b_wins", mk(ALU_ADD, 2, 0, 0, 0, 0, 0, 1, 1, 3),
                mk(ALU_ADD, 2, 0, 0, 0, 1, 0, 1, 1, 4), SEL_ALU, 0, 0, 32'hbbbb, 32'hbbbc);
        add_row("r0_write", mk(ALU_PASS2, 0, 0, 0, 0, 32'hdead, 0, 1, 1, 0),
                mk(ALU_PASS2, 0, 0, 0, 0, 32'hbeef, 0, 1, 1, 5), SEL_ALU, 0, 0,
                32'hdead, 32'hbeef);
        add_row("r0_read", mk(ALU_ADD, 0, 0, 0, 0, 5, 0, 1, 1, 6),
                mk(ALU_ADD, 0, 0, 5, 0, 0, 0, 0, 1, 7), SEL_ALU, 0, 0, 5, 32'hbeef);
        add_row("mul_lo_u", two, mk(ALU_ADD, 20, 32'hffffffff, 21, 32'hffffffff, 0, 0, 0,
                1, 9), SEL_LO, 0, 0, 2, ref_mul(32'hffffffff, 32'hffffffff, 0, 0));
        add_row("mul_hi_u", two, mk(ALU_ADD, 20, 32'hffffffff, 21, 32'hffffffff, 0, 0, 0,
                1, 9), SEL_HI, 0, 0, 2, ref_mul(32'hffffffff, 32'hffffffff, 0, 1));
        add_row("mul_lo_negneg", two, mk(ALU_ADD, 20, -3, 21, -5, 0, 0, 0, 1, 9), SEL_LO,
                1, 0, 2, ref_mul(-3, -5, 1, 0));
        add_row("mul_hi_negneg", two, mk(ALU_ADD, 20, -3, 21, -5, 0, 0, 0, 1, 9), SEL_HI,
                1, 0, 2, ref_mul(-3, -5, 1, 1));
        add_row("mul_hi_minmin", two, mk(ALU_ADD, 20, 32'h80000000, 21, 32'h80000000, 0, 0,
                0, 1, 9), SEL_HI, 1, 0, 2, ref_mul(32'h80000000, 32'h80000000, 1, 1));
        add_row("mul_hi_min7", two, mk(ALU_ADD, 20, 32'h80000000, 21, 7, 0, 0, 0, 1, 9),
                SEL_HI, 1, 0, 2, ref_mul(32'h80000000, 7, 1, 1));
        add_row("load_preset", two, mk(ALU_ADD, 20, 32'h40, 0, 0, 8, 0, 1, 1, 9), SEL_LOAD,
                0, 0, 2, 32'h48 ^ 32'h5a5a_0000);
        add_row("store_10", two, mk(ALU_ADD, 20, 32'h10, 21, 32'hcafef00d, 0, 0, 1, 0, 0),
                SEL_ALU, 0, 1, 2, 0);
        add_row("gap", two, mk(ALU_ADD, 20, 3, 0, 0, 4, 0, 1, 1, 12), SEL_ALU, 0, 0, 2, 7);
        add_row("load_10", two, mk(ALU_ADD, 20, 32'h10, 0, 0, 0, 0, 1, 1, 10), SEL_LOAD,
                0, 0, 2, 32'hcafef00d);
        add_row("store_20", two, mk(ALU_ADD, 20, 32'h20, 21, 32'h13572468, 0, 0, 1, 0, 0),
                SEL_ALU, 0, 1, 2, 0);
        add_row("load_20", two, mk(ALU_ADD, 20, 32'h1c, 0, 0, 4, 0, 1, 1, 13), SEL_LOAD,
                0, 0, 2, 32'h13572468);
        add_row("load_10_again", two, mk(ALU_ADD, 20, 32'h10, 0, 0, 0, 0, 1, 1, 14),
                SEL_LOAD, 0, 0, 2, 32'hcafef00d);
    endtask

    task automatic drive_idle();
        slot_a = '0;
        slot_b = '0;
        ctl_b  = '0;
    endtask

    task automatic check_wb(string name, wb_port_t exp, wb_port_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected we=%0b r%0d %h, actual we=%0b r%0d %h", name,
                     exp.we, exp.waddr, exp.wdata, act.we, act.waddr, act.wdata);
        end
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic take_wb(wb_port_t act);
        wb_port_t e;
        string    n;
        bit       ld;
        if (exp_q.size() == 0) begin
            errors++;
            $display("extra writeback to r%0d with no instruction waiting for it", act.waddr);
        end else begin
            e  = exp_q.pop_front();
            n  = name_q.pop_front();
            ld = load_q.pop_front();
            if (ld) begin
                check_word(n, e.wdata, act.wdata);
                if (act.waddr != e.waddr) begin
                    errors++;
                    $display("ERROR %s: expected r%0d, actual r%0d", n, e.waddr,
                             act.waddr);
                end
            end else begin
                check_wb(n, e, act);
            end
        end
    endtask

    task automatic accept_row(int i);
        if (tab_a[i].rf_we) begin
            exp_q.push_back(wb_port_t'{we: 1'b1, waddr: tab_a[i].rf_waddr,
                                       wdata: tab_ea[i]});
            name_q.push_back({names[i], "_a"});
            load_q.push_back(1'b0);
        end
        if (tab_b[i].rf_we) begin
            exp_q.push_back(wb_port_t'{we: 1'b1, waddr: tab_b[i].rf_waddr,
                                       wdata: tab_eb[i]});
            name_q.push_back({names[i], "_b"});
            load_q.push_back(tab_c[i].wb_sel.load);
        end
        if (tab_c[i].mem_we) begin
            stores++;
        end
    endtask

    initial begin
        int idx;
        bit driving;
        bit go;
        build_table();
        limit = names.size() * 5 + 20;
        drive_idle();
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        check_wb("reset_a", '0, wb_a);
        check_wb("reset_b", '0, wb_b);
        if (stall || dmem_req.rd || dmem_req.wr) begin
            errors++;
            $display("stall or a data port request is active right after reset");
        end
        rst_n   = 1'b1;
        idx     = 0;
        driving = 1'b0;
        go      = 1'b0;
        while (idx < names.size() || driving || exp_q.size() != 0) begin
            @(negedge clk);
            if (wb_a.we) take_wb(wb_a);
            if (wb_b.we) take_wb(wb_b);
            if (driving && go) begin          // Row passed an unstalled edge
                accept_row(idx);
                idx++;
            end
            if (idx < names.size()) begin
                slot_a  = tab_a[idx];
                slot_b  = tab_b[idx];
                ctl_b   = tab_c[idx];
                driving = 1'b1;
            end else begin
                drive_idle();
                driving = 1'b0;
            end
            go = !stall;
        end
        repeat (4) begin
            @(negedge clk);
            if (wb_a.we) take_wb(wb_a);
            if (wb_b.we) take_wb(wb_b);
        end
        check_word("store_count", word_t'(stores), word_t'(write_count));
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
